// File: rtl/i2cBusPkg.sv
// Bus timing is set for simulation; scale SclHalfPeriod to the system clock for a real SCL rate
`default_nettype none

package i2cBusPkg;

    typedef logic [9:0] halfCount_t;  // Half-period counter
    typedef logic [3:0] bitCount_t;   // Bit index, 8 is the acknowledge slot
    typedef logic [7:0] byte_t;

    // Clock cycles per SCL phase
    localparam halfCount_t SclHalfPeriod = 10'd16;

    // Bus sequencer states
    typedef enum logic [3:0] {
        Idle,
        Fetch,
        Execute,
        StartSda1,
        StartScl1,
        StartSda0,
        StartScl0,
        SendScl0,
        SendScl1,
        GetScl0,
        GetScl1,
        StopSda0,
        StopScl1,
        StopSda1
    } busState_t;

endpackage

`default_nettype wire

// File: rtl/ioExpPkg.sv
// Only expanders on the fixed 0100 address nibble with four registers are reachable
`default_nettype none

package ioExpPkg;

    typedef logic [2:0] expAddr_t;  // Hardware address pins of the expander
    typedef logic [1:0] regAddr_t;  // Register index inside the expander

    // Upper nibble of the 7-bit slave address
    localparam logic [3:0] ExpBaseAddr = 4'b0100;

    // Commands stored in the sequence rows
    typedef enum logic [2:0] {
        GoIdle,
        SendStart,
        SendStop,
        SendByte,
        GetByte
    } command_t;

endpackage

`default_nettype wire

// File: rtl/sclTimer.sv
// Counts only while the watched line shows the expected level, so a held-low SCL stalls the phase
`timescale 1ns/1ns
`default_nettype none

module sclTimer (
    input  wire  Clk_ik,
    input  wire  rstN_i,
    input  wire  restart_i,     // Pulse on every bus state change
    input  wire  watchScl_i,    // 1 watches SCL, 0 watches SDA
    input  wire  expectHigh_i,
    input  wire  Scl_i,
    input  wire  Sda_i,
    output logic halfDone_o,
    output logic midPoint_o
);
    import i2cBusPkg::*;

    halfCount_t count;
    logic       lineLevel;
    logic       levelOk;

    assign lineLevel = watchScl_i ? Scl_i : Sda_i;
    assign levelOk   = lineLevel == expectHigh_i;

    // A slave stretching SCL keeps the line away from the expected level,
    // which holds the count at zero until it lets go
    always_ff @(posedge Clk_ik) begin
        if (!rstN_i) begin
            count <= '0;
        end else if (restart_i || !levelOk) begin
            count <= '0;
        end else if (count != SclHalfPeriod) begin
            count <= count + 10'd1;   // Saturates so an idle bus does not wrap
        end
    end

    assign halfDone_o = count == SclHalfPeriod;
    assign midPoint_o = count == (SclHalfPeriod >> 1);  // Quarter of the SCL period

endmodule

`default_nettype wire

// File: rtl/i2cByteShifter.sv
// One byte per load, MSB first; the ninth bit is the acknowledge slot and is never shifted into data
`timescale 1ns/1ns
`default_nettype none

module i2cByteShifter (
    input  wire                     Clk_ik,
    input  wire                     rstN_i,
    input  wire                     loadByte_i,
    input  wire  i2cBusPkg::byte_t  byte_i,
    input  wire                     shiftTx_i,   // End of a sent bit's SCL high phase
    input  wire                     shiftRx_i,   // End of a received bit's SCL high phase
    input  wire                     Sda_i,
    output logic                    txLow_o,
    output logic                    byteDone_o,
    output logic                    nack_o,
    output i2cBusPkg::byte_t        rxByte_o
);
    import i2cBusPkg::*;

    bitCount_t bitCount;
    byte_t     shiftReg;

    // Bit counter and acknowledge capture
    always_ff @(posedge Clk_ik) begin
        if (!rstN_i) begin
            bitCount <= '0;
            nack_o   <= 1'b0;
        end else if (loadByte_i) begin
            bitCount <= '0;
        end else if (shiftTx_i || shiftRx_i) begin
            if (bitCount != 4'd9) begin
                bitCount <= bitCount + 4'd1;
            end
            if (shiftTx_i && bitCount == 4'd8) begin
                nack_o <= Sda_i;   // High means nobody acknowledged
            end
        end
    end

    always_ff @(posedge Clk_ik) begin
        if (loadByte_i) begin
            shiftReg <= byte_i;
        end else if (shiftTx_i) begin
            shiftReg <= {shiftReg[6:0], 1'b0};
        end else if (shiftRx_i && bitCount < 4'd8) begin
            shiftReg <= {shiftReg[6:0], Sda_i};   // Received bits enter at the LSB
        end
    end

    // SDA is released during the acknowledge slot and after it
    assign txLow_o    = !shiftReg[7] && bitCount < 4'd8;
    assign byteDone_o = bitCount == 4'd9;
    assign rxByte_o   = shiftReg;

endmodule

`default_nettype wire

// File: rtl/ioExpCmdRom.sv
// Single-register write and single-byte read sequences only; rows past the end read as GoIdle
`timescale 1ns/1ns
`default_nettype none

module ioExpCmdRom (
    input  wire                      Clk_ik,
    input  wire                      rstN_i,
    input  wire                      captureReq_i,
    input  wire                      isWrite_i,
    input  wire  ioExpPkg::expAddr_t expAddr_i,
    input  wire  ioExpPkg::regAddr_t regAddr_i,
    input  wire  i2cBusPkg::byte_t   data_i,
    input  wire                      nextCmd_i,
    output ioExpPkg::command_t       cmd_o,
    output i2cBusPkg::byte_t         cmdByte_o
);
    import ioExpPkg::*;
    import i2cBusPkg::*;

    logic       isWriteQ;
    logic [2:0] ptr;        // Row 7 is GoIdle in both sequences
    expAddr_t   expAddrQ;
    regAddr_t   regAddrQ;
    byte_t      dataQ;
    logic [6:0] devAddr;
    command_t   rowCmd;
    byte_t      rowByte;

    assign devAddr = {ExpBaseAddr, expAddrQ};

    always_comb begin
        if (isWriteQ) begin
            case (ptr)
                3'd0:             rowCmd = SendStart;
                3'd1, 3'd2, 3'd3: rowCmd = SendByte;
                3'd4:             rowCmd = SendStop;
                default:          rowCmd = GoIdle;
            endcase
        end else begin
            case (ptr)
                3'd0, 3'd3:       rowCmd = SendStart;  // Row 3 is the repeated start
                3'd1, 3'd2, 3'd4: rowCmd = SendByte;
                3'd5:             rowCmd = GetByte;    // Single byte, master NACKs
                3'd6:             rowCmd = SendStop;
                default:          rowCmd = GoIdle;
            endcase
        end
        // Byte column is shared, start and stop rows ignore it
        case (ptr)
            3'd1:    rowByte = {devAddr, 1'b0};    // Slave address, write
            3'd2:    rowByte = {6'b0, regAddrQ};
            3'd3:    rowByte = dataQ;
            3'd4:    rowByte = {devAddr, 1'b1};    // Slave address, read
            default: rowByte = 8'h00;
        endcase
    end

    always_ff @(posedge Clk_ik) begin
        if (!rstN_i) begin
            isWriteQ <= 1'b0;
            ptr      <= '0;
            cmd_o    <= GoIdle;
        end else if (captureReq_i) begin
            isWriteQ <= isWrite_i;
            ptr      <= '0;
            cmd_o    <= SendStart;  // Row 0 of both sequences, ready for the first Fetch
        end else begin
            cmd_o <= rowCmd;
            if (nextCmd_i && ptr != 3'd7) begin
                ptr <= ptr + 3'd1;
            end
        end
    end

    always_ff @(posedge Clk_ik) begin
        if (captureReq_i) begin
            expAddrQ  <= expAddr_i;
            regAddrQ  <= regAddr_i;
            dataQ     <= data_i;
            cmdByte_o <= 8'h00;
        end else begin
            cmdByte_o <= rowByte;
        end
    end

endmodule

`default_nettype wire

// File: rtl/i2cSeqFsm.sv
// Requests are levels taken only in Idle with busy low; write wins when both are set
`timescale 1ns/1ns
`default_nettype none

module i2cSeqFsm (
    input  wire                      Clk_ik,
    input  wire                      rstN_i,
    input  wire                      wrReq_i,
    input  wire                      rdReq_i,
    input  wire  ioExpPkg::command_t cmd_i,
    input  wire                      halfDone_i,
    input  wire                      midPoint_i,
    input  wire                      txLow_i,
    input  wire                      byteDone_i,
    input  wire                      nack_i,
    input  wire  i2cBusPkg::byte_t   rxByte_i,
    output logic                     captureReq_o,
    output logic                     isWrite_o,
    output logic                     nextCmd_o,
    output logic                     loadByte_o,
    output logic                     shiftTx_o,
    output logic                     shiftRx_o,
    output logic                     restart_o,
    output logic                     watchScl_o,
    output logic                     expectHigh_o,
    output logic                     SclOe_o,       // 1 pulls SCL low
    output logic                     SdaOe_o,       // 1 pulls SDA low
    output logic                     busy_o,
    output logic                     wrOn_o,
    output logic                     rdOn_o,
    output logic                     newByteRead_o,
    output i2cBusPkg::byte_t         byteOut_o,
    output logic                     ackError_o
);
    import i2cBusPkg::*;
    import ioExpPkg::*;

    busState_t state;
    busState_t stateNext;
    command_t  lastCmd;   // Command being executed, read back in the next Fetch
    logic      accept;

    assign accept       = state == Idle && !busy_o && (wrReq_i || rdReq_i);
    assign captureReq_o = accept;
    assign isWrite_o    = wrReq_i;
    assign nextCmd_o    = state == Fetch;
    assign loadByte_o   = state == Fetch;
    assign shiftTx_o    = state == SendScl1 && halfDone_i;
    assign shiftRx_o    = state == GetScl1 && halfDone_i;
    assign restart_o    = stateNext != state;

    always_comb begin
        stateNext = state;
        case (state)
            Idle:      if (accept) stateNext = Fetch;
            Fetch:     stateNext = Execute;
            Execute: begin
                case (cmd_i)
                    SendStart: stateNext = StartSda1;
                    SendByte:  stateNext = SendScl0;
                    GetByte:   stateNext = GetScl0;
                    SendStop:  stateNext = StopSda0;
                    default:   stateNext = Idle;
                endcase
            end
            StartSda1: if (halfDone_i) stateNext = StartScl1;
            StartScl1: if (halfDone_i) stateNext = StartSda0;
            StartSda0: if (halfDone_i) stateNext = StartScl0;
            StartScl0: if (halfDone_i) stateNext = Fetch;
            SendScl0:  if (halfDone_i) stateNext = byteDone_i ? Fetch : SendScl1;
            SendScl1:  if (halfDone_i) stateNext = SendScl0;
            GetScl0:   if (halfDone_i) stateNext = byteDone_i ? Fetch : GetScl1;
            GetScl1:   if (halfDone_i) stateNext = GetScl0;
            StopSda0:  if (halfDone_i) stateNext = StopScl1;
            StopScl1:  if (halfDone_i) stateNext = StopSda1;
            StopSda1:  if (halfDone_i) stateNext = Fetch;
            default:   stateNext = Idle;
        endcase
    end

    // Line and level the timer waits for, SCL high unless listed
    always_comb begin
        watchScl_o   = 1'b1;
        expectHigh_o = 1'b1;
        case (state)
            StartSda1, StopSda1: watchScl_o = 1'b0;
            StartSda0, StopSda0: begin
                watchScl_o   = 1'b0;
                expectHigh_o = 1'b0;
            end
            StartScl0, SendScl0, GetScl0: expectHigh_o = 1'b0;
            default: ;
        endcase
    end

    always_ff @(posedge Clk_ik) begin
        if (!rstN_i) begin
            state         <= Idle;
            lastCmd       <= GoIdle;
            SclOe_o       <= 1'b0;
            SdaOe_o       <= 1'b0;
            busy_o        <= 1'b0;
            wrOn_o        <= 1'b0;
            rdOn_o        <= 1'b0;
            newByteRead_o <= 1'b0;
            ackError_o    <= 1'b0;
        end else begin
            state         <= stateNext;
            newByteRead_o <= 1'b0;
            ackError_o    <= 1'b0;
            case (state)
                Idle: begin
                    SclOe_o <= 1'b0;
                    SdaOe_o <= 1'b0;
                    lastCmd <= GoIdle;   // No byte status on the first Fetch
                    busy_o  <= accept;
                    wrOn_o  <= accept && wrReq_i;
                    rdOn_o  <= accept && !wrReq_i;
                end
                Fetch: begin
                    newByteRead_o <= lastCmd == GetByte;
                    ackError_o    <= lastCmd == SendByte && nack_i;
                end
                Execute:   lastCmd <= cmd_i;
                StartSda1: SdaOe_o <= 1'b0;
                StartScl1: SclOe_o <= 1'b0;
                StartSda0: SdaOe_o <= 1'b1;   // Start condition, SDA falls with SCL high
                StartScl0: SclOe_o <= 1'b1;
                SendScl0: begin
                    SclOe_o <= 1'b1;
                    if (midPoint_i) begin
                        SdaOe_o <= txLow_i;   // Data changes well inside SCL low
                    end
                end
                SendScl1:  SclOe_o <= 1'b0;
                GetScl0: begin
                    SclOe_o <= 1'b1;
                    SdaOe_o <= 1'b0;          // Also the NACK of the single read byte
                end
                GetScl1:   SclOe_o <= 1'b0;
                StopSda0:  SdaOe_o <= 1'b1;
                StopScl1:  SclOe_o <= 1'b0;
                StopSda1:  SdaOe_o <= 1'b0;   // Stop condition
                default: begin
                    SclOe_o <= 1'b0;
                    SdaOe_o <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge Clk_ik) begin
        if (state == Fetch && lastCmd == GetByte) begin
            byteOut_o <= rxByte_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/i2cExpMaster.sv
// Open-drain lines come out as pull-low enables; the caller resolves the wired-AND into Scl_i and Sda_i
`timescale 1ns/1ns
`default_nettype none

module i2cExpMaster (
    input  wire                      Clk_ik,
    input  wire                      rstN_i,
    input  wire                      wrReq_i,
    input  wire                      rdReq_i,
    input  wire  ioExpPkg::expAddr_t expAddr_i,
    input  wire  ioExpPkg::regAddr_t regAddr_i,
    input  wire  i2cBusPkg::byte_t   data_i,
    output logic                     busy_o,
    output logic                     wrOn_o,
    output logic                     rdOn_o,
    output logic                     newByteRead_o,
    output i2cBusPkg::byte_t         byteOut_o,
    output logic                     ackError_o,
    output logic                     SclOe_o,
    output logic                     SdaOe_o,
    input  wire                      Scl_i,
    input  wire                      Sda_i
);
    import i2cBusPkg::*;
    import ioExpPkg::*;

    // Sequencer to command ROM
    logic     captureReq;
    logic     isWrite;
    logic     nextCmd;
    command_t cmd;
    byte_t    cmdByte;
    // Sequencer to byte shifter
    logic     loadByte;
    logic     shiftTx;
    logic     shiftRx;
    logic     txLow;
    logic     byteDone;
    logic     nack;
    byte_t    rxByte;
    // Sequencer to timer
    logic     restart;
    logic     watchScl;
    logic     expectHigh;
    logic     halfDone;
    logic     midPoint;

    sclTimer sclTimer_i (
        .Clk_ik(Clk_ik), .rstN_i(rstN_i), .restart_i(restart), .watchScl_i(watchScl),
        .expectHigh_i(expectHigh), .Scl_i(Scl_i), .Sda_i(Sda_i),
        .halfDone_o(halfDone), .midPoint_o(midPoint)
    );

    i2cByteShifter i2cByteShifter_i (
        .Clk_ik(Clk_ik), .rstN_i(rstN_i), .loadByte_i(loadByte), .byte_i(cmdByte),
        .shiftTx_i(shiftTx), .shiftRx_i(shiftRx), .Sda_i(Sda_i),
        .txLow_o(txLow), .byteDone_o(byteDone), .nack_o(nack), .rxByte_o(rxByte)
    );

    ioExpCmdRom ioExpCmdRom_i (
        .Clk_ik(Clk_ik), .rstN_i(rstN_i), .captureReq_i(captureReq), .isWrite_i(isWrite),
        .expAddr_i(expAddr_i), .regAddr_i(regAddr_i), .data_i(data_i), .nextCmd_i(nextCmd),
        .cmd_o(cmd), .cmdByte_o(cmdByte)
    );

    i2cSeqFsm i2cSeqFsm_i (
        .Clk_ik(Clk_ik), .rstN_i(rstN_i), .wrReq_i(wrReq_i), .rdReq_i(rdReq_i),
        .cmd_i(cmd), .halfDone_i(halfDone), .midPoint_i(midPoint), .txLow_i(txLow),
        .byteDone_i(byteDone), .nack_i(nack), .rxByte_i(rxByte),
        .captureReq_o(captureReq), .isWrite_o(isWrite), .nextCmd_o(nextCmd),
        .loadByte_o(loadByte), .shiftTx_o(shiftTx), .shiftRx_o(shiftRx),
        .restart_o(restart), .watchScl_o(watchScl), .expectHigh_o(expectHigh),
        .SclOe_o(SclOe_o), .SdaOe_o(SdaOe_o), .busy_o(busy_o), .wrOn_o(wrOn_o),
        .rdOn_o(rdOn_o), .newByteRead_o(newByteRead_o), .byteOut_o(byteOut_o),
        .ackError_o(ackError_o)
    );

endmodule

`default_nettype wire

// File: verification/ioExpSlaveModel.sv
// Samples the resolved lines on the system clock, so it reacts one cycle after each SCL edge
`timescale 1ns/1ns
`default_nettype none

module ioExpSlaveModel #(
    parameter logic [2:0] HwAddr = 3'b000
) (
    input  wire        Clk_ik,
    input  wire        rstN_i,
    input  wire        Scl_i,
    input  wire        Sda_i,
    input  wire  [7:0] stretchLen_i,   // Cycles SCL is held low after each fall, 0 disables
    output logic       sclLow_o,
    output logic       sdaLow_o,
    output logic       protoErr_o      // Sticky
);
    import ioExpPkg::*;

    logic [7:0] regs [4];
    logic       sclQ;
    logic       sdaQ;
    logic       inFrame;
    logic [3:0] bitIdx;       // Rising edges seen in the current byte, 1 at a start or stop
    logic [1:0] byteNum;
    logic       selected;
    logic       readMode;
    logic       sending;
    logic [1:0] regPtr;
    logic [7:0] rxShift;
    logic [7:0] txByte;
    logic [7:0] stretchCnt;
    logic       addrMatch;

    assign sclLow_o  = stretchCnt != 8'd0;
    assign addrMatch = rxShift[7:1] == {ExpBaseAddr, HwAddr};

    always_ff @(posedge Clk_ik) begin
        if (!rstN_i) begin
            regs       <= '{default: 8'h00};
            sclQ       <= 1'b1;
            sdaQ       <= 1'b1;
            inFrame    <= 1'b0;
            bitIdx     <= '0;
            byteNum    <= '0;
            selected   <= 1'b0;
            readMode   <= 1'b0;
            sending    <= 1'b0;
            regPtr     <= '0;
            rxShift    <= '0;
            txByte     <= '0;
            stretchCnt <= '0;
            sdaLow_o   <= 1'b0;
            protoErr_o <= 1'b0;
        end else begin
            sclQ <= Scl_i;
            sdaQ <= Sda_i;
            if (stretchCnt != 8'd0) stretchCnt <= stretchCnt - 8'd1;
            if (Scl_i != sclQ && Sda_i != sdaQ) protoErr_o <= 1'b1;  // Both lines moved at once
            if (sclQ && Scl_i && sdaQ && !Sda_i) begin              // Start or repeated start
                if (inFrame && bitIdx != 4'd1) protoErr_o <= 1'b1;
                inFrame  <= 1'b1;
                bitIdx   <= '0;
                byteNum  <= '0;
                selected <= 1'b0;
                sending  <= 1'b0;
                sdaLow_o <= 1'b0;
            end else if (sclQ && Scl_i && !sdaQ && Sda_i) begin      // Stop
                if (!inFrame || bitIdx != 4'd1) protoErr_o <= 1'b1;
                inFrame  <= 1'b0;
                sdaLow_o <= 1'b0;
            end else if (sclQ && Scl_i && Sda_i != sdaQ) begin
                protoErr_o <= 1'b1;   // SDA moved while SCL was high
            end else if (inFrame && !sclQ && Scl_i) begin
                if (bitIdx < 4'd8) rxShift <= {rxShift[6:0], Sda_i};
                bitIdx <= bitIdx + 4'd1;
            end else if (inFrame && sclQ && !Scl_i) begin
                stretchCnt <= stretchLen_i;
                if (bitIdx == 4'd8 && sending) begin
                    sdaLow_o <= 1'b0;  // Master owns this acknowledge slot
                end else if (bitIdx == 4'd8) begin
                    sdaLow_o <= (byteNum == 2'd0) ? addrMatch : selected;
                    byteNum  <= byteNum + 2'd1;
                    if (byteNum == 2'd0) begin
                        selected <= addrMatch;
                        readMode <= rxShift[0];
                    end
                    if (byteNum == 2'd1 && selected) regPtr <= rxShift[1:0];
                    if (byteNum == 2'd2 && selected) regs[regPtr] <= rxShift;
                end else if (bitIdx == 4'd9) begin
                    bitIdx   <= '0;
                    sdaLow_o <= 1'b0;
                    if (sending) begin
                        sending <= 1'b0;
                    end else if (selected && readMode && byteNum == 2'd1) begin
                        sending  <= 1'b1;
                        sdaLow_o <= !regs[regPtr][7];
                        txByte   <= {regs[regPtr][6:0], 1'b0};
                    end
                end else if (sending) begin
                    sdaLow_o <= !txByte[7];
                    txByte   <= {txByte[6:0], 1'b0};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/i2cSeqFsm_props.sv
// Checks the sequencer through its registered outputs; reset disables all properties
`timescale 1ns/1ns
`default_nettype none

module i2cSeqFsm_props (
    input  wire                       Clk_ik,
    input  wire                       rstN_i,
    input  wire  i2cBusPkg::busState_t state_i,
    input  wire                       sclOe_i,
    input  wire                       sdaOe_i,
    input  wire                       busy_i,
    input  wire                       wrOn_i,
    input  wire                       rdOn_i
);
    import i2cBusPkg::*;

    logic inStartStop;

    assign inStartStop = state_i inside {StartSda1, StartScl1, StartSda0, StartScl0,
                                         StopSda0, StopScl1, StopSda1};

    // Data may only move while the master holds SCL low
    sdaChangeSclLow: assert property (@(posedge Clk_ik) disable iff (!rstN_i)
        (sdaOe_i != $past(sdaOe_i)) |-> ($past(sclOe_i) || $past(inStartStop)))
        else $error("SDA enable changed with SCL released outside start or stop");

    busyWhileActive: assert property (@(posedge Clk_ik) disable iff (!rstN_i)
        (state_i != Idle) |-> busy_i)
        else $error("busy_o low while the sequencer is active");

    oneDirection: assert property (@(posedge Clk_ik) disable iff (!rstN_i)
        !(wrOn_i && rdOn_i))
        else $error("wrOn_o and rdOn_o high together");

endmodule

bind i2cSeqFsm i2cSeqFsm_props i2cSeqFsm_props_i (
    .Clk_ik(Clk_ik), .rstN_i(rstN_i), .state_i(state), .sclOe_i(SclOe_o),
    .sdaOe_i(SdaOe_o), .busy_i(busy_o), .wrOn_i(wrOn_o), .rdOn_i(rdOn_o)
);

`default_nettype wire

// File: verification/i2cExpMasterTb.sv
// Slave sits at hardware address 101; inputs change on rising edges, outputs are read on falling edges
`timescale 1ns/1ns
`default_nettype none

module i2cExpMasterTb;
    import i2cBusPkg::*;
    import ioExpPkg::*;

    localparam expAddr_t SlaveAddr = 3'b101;
    localparam int       WaitLimit = 20000;   // Cycles, covers the longest stretched transfer

    logic     Clk_ik;
    logic     rstN;
    logic     wrReq;
    logic     rdReq;
    expAddr_t expAddr;
    regAddr_t regAddr;
    byte_t    data;
    logic     busy;
    logic     wrOn;
    logic     rdOn;
    logic     newByteRead;
    logic     ackError;
    byte_t    byteOut;
    logic     sclOeM;
    logic     sdaOeM;
    logic     sclLowS;
    logic     sdaLowS;
    logic     protoErr;
    logic     sclLine;
    logic     sdaLine;
    logic [7:0]  stretchLen;
    logic [31:0] rngState;
    byte_t       model [4];   // Expected slave registers

    // Wired-AND with pull-ups
    assign sclLine = !(sclOeM || sclLowS);
    assign sdaLine = !(sdaOeM || sdaLowS);

    i2cExpMaster i2cExpMaster_i (
        .Clk_ik(Clk_ik), .rstN_i(rstN), .wrReq_i(wrReq), .rdReq_i(rdReq),
        .expAddr_i(expAddr), .regAddr_i(regAddr), .data_i(data), .busy_o(busy),
        .wrOn_o(wrOn), .rdOn_o(rdOn), .newByteRead_o(newByteRead), .byteOut_o(byteOut),
        .ackError_o(ackError), .SclOe_o(sclOeM), .SdaOe_o(sdaOeM),
        .Scl_i(sclLine), .Sda_i(sdaLine)
    );

    ioExpSlaveModel #(.HwAddr(SlaveAddr)) ioExpSlaveModel_i (
        .Clk_ik(Clk_ik), .rstN_i(rstN), .Scl_i(sclLine), .Sda_i(sdaLine),
        .stretchLen_i(stretchLen), .sclLow_o(sclLowS), .sdaLow_o(sdaLowS),
        .protoErr_o(protoErr)
    );

    always #20 Clk_ik = !Clk_ik;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic failRun(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // One request, held until busy_o rises, then scrambled inputs until busy_o falls
    task automatic runTransfer(input logic wr, input logic rd, input expAddr_t a,
                               input regAddr_t r, input byte_t d, output logic ackSeen,
                               output int newCount, output byte_t got);
        int n;
        @(posedge Clk_ik);
        wrReq   <= wr;
        rdReq   <= rd;
        expAddr <= a;
        regAddr <= r;
        data    <= d;
        n = 0;
        do begin
            @(negedge Clk_ik);
            n++;
        end while (!busy && n < WaitLimit);
        assert (busy) else failRun("Timed out waiting for busy_o to rise");
        assert (wrOn == wr) else failRun($sformatf("Fail wrOn_o got %h expected %h", wrOn, wr));
        assert (rdOn == !wr) else failRun($sformatf("Fail rdOn_o got %h expected %h", rdOn, !wr));
        rngState = xorshift32(rngState);
        @(posedge Clk_ik);
        wrReq   <= 1'b0;
        rdReq   <= 1'b0;
        expAddr <= rngState[2:0];
        regAddr <= rngState[4:3];
        data    <= rngState[12:5];
        ackSeen  = 1'b0;
        newCount = 0;
        got      = 8'h00;
        n = 0;
        do begin
            @(negedge Clk_ik);
            n++;
            ackSeen = ackSeen | ackError;
            if (newByteRead) begin
                newCount++;
                got = byteOut;
            end
        end while (busy && n < WaitLimit);
        assert (!busy) else failRun("Timed out waiting for busy_o to fall");
    endtask

    task automatic checkedTransfer(input logic wr, input logic rd, input expAddr_t a,
                                   input regAddr_t r, input byte_t d);
        logic  ackSeen;
        int    newCount;
        byte_t got;
        byte_t expected;
        logic  hit;
        runTransfer(wr, rd, a, r, d, ackSeen, newCount, got);
        hit = a == SlaveAddr;
        assert (ackSeen == !hit)
            else failRun($sformatf("Fail ackError_o got %h expected %h", ackSeen, !hit));
        if (wr) begin
            if (hit) model[r] = d;
            assert (newCount == 0) else failRun("newByteRead_o pulsed during a write");
        end else begin
            expected = hit ? model[r] : 8'hFF;   // Released bus reads as ones
            assert (newCount == 1)
                else failRun($sformatf("Fail newByteRead_o pulses got %h expected 1", newCount));
            assert (got == expected)
                else failRun($sformatf("Fail byteOut_o got %h expected %h", got, expected));
        end
    endtask

    task automatic randomTransfer(input expAddr_t a);
        rngState = xorshift32(rngState);
        checkedTransfer(rngState[0], !rngState[0], a, rngState[2:1], rngState[10:3]);
    endtask

    always @(negedge Clk_ik) begin
        if (rstN) begin
            assert (!protoErr) else failRun("Slave saw an illegal start, stop or SDA change");
        end
    end

    initial begin
        expAddr_t bad;
        regAddr_t r;
        Clk_ik     = 1'b0;
        rstN       = 1'b0;
        wrReq      = 1'b0;
        rdReq      = 1'b0;
        expAddr    = '0;
        regAddr    = '0;
        data       = '0;
        stretchLen = '0;
        rngState   = 32'h6bd17b91;
        model      = '{default: 8'h00};
        repeat (3) @(posedge Clk_ik);
        rstN <= 1'b1;
        repeat (4) begin
            @(negedge Clk_ik);
            assert ({busy, wrOn, rdOn, newByteRead, ackError, sclOeM, sdaOeM} == 7'h00)
                else failRun($sformatf("Fail idle outputs got %h expected 00",
                    {busy, wrOn, rdOn, newByteRead, ackError, sclOeM, sdaOeM}));
        end
        for (int i = 0; i < 4; i++) begin
            rngState = xorshift32(rngState);
            checkedTransfer(1'b1, 1'b0, SlaveAddr, regAddr_t'(i), rngState[7:0]);
        end
        repeat (12) randomTransfer(SlaveAddr);
        // Nobody answers at these addresses
        for (int i = 0; i < 4; i++) begin
            rngState = xorshift32(rngState);
            bad = rngState[2:0];
            if (bad == SlaveAddr) bad = bad ^ 3'b001;
            checkedTransfer(rngState[20], !rngState[20], bad, rngState[4:3], rngState[12:5]);
        end
        // Write wins over a simultaneous read
        rngState = xorshift32(rngState);
        r = rngState[1:0];
        checkedTransfer(1'b1, 1'b1, SlaveAddr, r, rngState[9:2]);
        checkedTransfer(1'b0, 1'b1, SlaveAddr, r, 8'h00);
        repeat (16) begin
            rngState = xorshift32(rngState);
            @(posedge Clk_ik);
            stretchLen <= {2'b00, rngState[5:0]};
            randomTransfer(SlaveAddr);
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/i2cBusPkg.sv
rtl/ioExpPkg.sv
rtl/sclTimer.sv
rtl/i2cByteShifter.sv
rtl/ioExpCmdRom.sv
rtl/i2cSeqFsm.sv
rtl/i2cExpMaster.sv
verification/ioExpSlaveModel.sv
verification/i2cSeqFsm_props.sv
verification/i2cExpMasterTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; a $fatal in the run gives a failing status

cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -j 0 \
        --top-module i2cExpMasterTb -f verilog.f -o i2cExpMasterSim \
    && ./obj_dir/i2cExpMasterSim \
    || { echo "Simulation run failed"; exit 1; }
